// File: rtl/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// data and address width
`define DC_WORD_W      32

// two-way, 8 sets, two words per block
`define DC_SETS        8
`define DC_IDX_W       3
`define DC_BLK_WORDS   2

// what is left of the address after idx, blkoff and bytoff
`define DC_TAG_W       26

// hit count lands here once the flush is done
`define DC_HITCNT_ADDR 32'h3100

`endif

// File: rtl/dcache_pkg.sv
`default_nettype none

`include "dcache_config.svh"

package dcache_pkg;

   typedef logic [`DC_WORD_W-1:0] word_t;

   typedef struct packed {
      logic [`DC_TAG_W-1:0] tag;
      logic [`DC_IDX_W-1:0] idx;
      logic                 blkoff;
      logic [1:0]           bytoff;
   } dc_addr_t;

   // same address word, seen raw or split into fields
   typedef union packed {
      word_t    raw;
      dc_addr_t fld;
   } dc_addr_u;

   typedef struct packed {
      logic     ren;
      logic     wen;
      dc_addr_u addr;
      word_t    store;
   } cpu_req_t;

   typedef struct packed {
      logic     ren;
      logic     wen;
      dc_addr_u addr;
      word_t    store;
   } mem_req_t;

   typedef struct packed {
      logic [`DC_TAG_W-1:0]          tag;
      logic                          valid;
      logic                          dirty;
      word_t [`DC_BLK_WORDS-1:0]     data;
   } dc_line_t;

   typedef struct packed {
      logic                 en;        // data word write
      logic [`DC_IDX_W-1:0] idx;
      logic                 wsel;      // word within block
      word_t                data;
      logic                 set_line;  // tag load, valid, clean
      logic                 dirty_set;
      logic                 invalidate;
   } way_wr_t;

   typedef enum logic [3:0] {
      idle,
      wb1,
      wb2,
      load1,
      load2,
      flush1,
      flush2,
      cnt_wr,
      halted
   } dc_state_t;

endpackage

`default_nettype wire

// File: rtl/dcache_way.sv
`timescale 1ns/10ps
`default_nettype none

`include "dcache_config.svh"

module dcache_way
   import dcache_pkg::*;
(
   input  logic                 CLK,
   input  logic                 nRST,
   input  logic [`DC_IDX_W-1:0] rd_idx,
   input  logic [`DC_TAG_W-1:0] rd_tag,
   input  way_wr_t              wr,
   output logic                 hit,
   output dc_line_t             line
);

   logic [`DC_TAG_W-1:0]      tag_q [`DC_SETS];
   word_t [`DC_BLK_WORDS-1:0] data_q [`DC_SETS];
   logic [`DC_SETS-1:0]       valid_q;
   logic [`DC_SETS-1:0]       dirty_q;

   // state bits per line
   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         valid_q <= '0;
         dirty_q <= '0;
      end
      else
      begin
         if (wr.set_line)
         begin
            valid_q[wr.idx] <= 1'b1;
            dirty_q[wr.idx] <= 1'b0;
         end
         if (wr.dirty_set)
            dirty_q[wr.idx] <= 1'b1;   // overrides the clean from set_line
         if (wr.invalidate)
         begin
            valid_q[wr.idx] <= 1'b0;
            dirty_q[wr.idx] <= 1'b0;
         end
      end
   end

   // payload storage
   always_ff @(posedge CLK)
   begin
      if (wr.en)
         data_q[wr.idx][wr.wsel] <= wr.data;
      if (wr.set_line)
         tag_q[wr.idx] <= rd_tag;   // fill tag is the lookup tag
   end

   // combinational lookup
   always_comb
   begin
      line.tag   = tag_q[rd_idx];
      line.valid = valid_q[rd_idx];
      line.dirty = dirty_q[rd_idx];
      line.data  = data_q[rd_idx];
   end

   assign hit = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

endmodule

`default_nettype wire

// File: rtl/dcache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "dcache_config.svh"

module dcache_ctrl
   import dcache_pkg::*;
(
   input  logic                 CLK,
   input  logic                 nRST,
   input  cpu_req_t             cpu_req,
   input  logic                 halt,
   output logic                 hit,
   output word_t                load,
   output logic                 flushed,
   output mem_req_t             mem_req,
   input  logic                 mem_wait,
   input  word_t                mem_load,
   output logic [`DC_IDX_W-1:0] rd_idx,
   output logic [`DC_TAG_W-1:0] rd_tag,
   input  logic                 hit0,
   input  logic                 hit1,
   input  dc_line_t             line0,
   input  dc_line_t             line1,
   output way_wr_t              wr0,
   output way_wr_t              wr1
);

   dc_state_t            state_q, state_d;
   logic [`DC_SETS-1:0]  lru_q;         // per set, way to evict next
   logic                 vic_q, vic_d;
   logic [`DC_IDX_W-1:0] fset_q, fset_d;
   logic                 fway_q, fway_d;
   word_t                count_q;
   logic                 count_en;
   logic                 lru_en;
   logic                 lru_way;
   logic                 req;
   logic                 hway;
   logic                 victim;
   logic                 sel;
   dc_line_t             sline;
   logic                 last_slot;
   logic [`DC_IDX_W-1:0] fset_nx;
   logic                 fway_nx;
   logic [`DC_IDX_W-1:0] req_idx;
   logic                 blkoff;
   way_wr_t              wr_c;
   logic                 wr_sel;

   assign req_idx = cpu_req.addr.fld.idx;
   assign blkoff  = cpu_req.addr.fld.blkoff;
   assign req     = cpu_req.ren | cpu_req.wen;
   assign hway    = hit1;

   // invalid way first, else lru
   assign victim = !line0.valid ? 1'b0 : (!line1.valid ? 1'b1 : lru_q[req_idx]);

   assign rd_idx = (state_q == flush1 || state_q == flush2) ? fset_q : req_idx;
   assign rd_tag = cpu_req.addr.fld.tag;

   // line under work: flush slot, candidate victim, or saved victim
   always_comb
   begin
      if (state_q == flush1 || state_q == flush2)
         sel = fway_q;
      else if (state_q == idle)
         sel = victim;
      else
         sel = vic_q;
   end

   assign sline = sel ? line1 : line0;

   // flush walk goes way 0, way 1, then next set
   assign last_slot = (fset_q == `DC_IDX_W'(`DC_SETS - 1)) && fway_q;
   assign fway_nx   = ~fway_q;
   assign fset_nx   = fway_q ? fset_q + 1'b1 : fset_q;

   assign wr0 = wr_sel ? '0 : wr_c;
   assign wr1 = wr_sel ? wr_c : '0;

   always_comb
   begin
      state_d  = state_q;
      vic_d    = vic_q;
      fset_d   = fset_q;
      fway_d   = fway_q;
      hit      = 1'b0;
      flushed  = 1'b0;
      load     = hway ? line1.data[blkoff] : line0.data[blkoff];
      count_en = 1'b0;
      lru_en   = 1'b0;
      lru_way  = hway;
      mem_req  = '0;
      wr_c     = '0;
      wr_c.idx = req_idx;
      wr_sel   = vic_q;

      case (state_q)
         idle:
         begin
            if (halt)
            begin
               state_d = flush1;
               fset_d  = '0;
               fway_d  = 1'b0;
            end
            else if (req && (hit0 || hit1))
            begin
               hit      = 1'b1;
               count_en = 1'b1;
               lru_en   = 1'b1;
               if (cpu_req.wen)
               begin
                  wr_sel         = hway;
                  wr_c.en        = 1'b1;
                  wr_c.wsel      = blkoff;
                  wr_c.data      = cpu_req.store;
                  wr_c.dirty_set = 1'b1;
               end
            end
            else if (req)
            begin
               vic_d   = victim;
               state_d = (sline.valid && sline.dirty) ? wb1 : load1;
            end
            else
               hit = 1'b1;
         end
         wb1:
         begin
            mem_req.wen             = 1'b1;
            mem_req.addr.fld.tag    = sline.tag;
            mem_req.addr.fld.idx    = req_idx;
            mem_req.addr.fld.blkoff = 1'b0;
            mem_req.store           = sline.data[0];
            if (!mem_wait)
               state_d = wb2;
         end
         wb2:
         begin
            mem_req.wen             = 1'b1;
            mem_req.addr.fld.tag    = sline.tag;
            mem_req.addr.fld.idx    = req_idx;
            mem_req.addr.fld.blkoff = 1'b1;
            mem_req.store           = sline.data[1];
            if (!mem_wait)
               state_d = load1;
         end
         load1:
         begin
            mem_req.ren             = 1'b1;
            mem_req.addr.fld.tag    = rd_tag;
            mem_req.addr.fld.idx    = req_idx;
            mem_req.addr.fld.blkoff = ~blkoff;   // other word first
            if (!mem_wait)
            begin
               wr_c.en       = 1'b1;
               wr_c.wsel     = ~blkoff;
               wr_c.data     = mem_load;
               wr_c.set_line = 1'b1;
               state_d       = load2;
            end
         end
         load2:
         begin
            mem_req.ren             = 1'b1;
            mem_req.addr.fld.tag    = rd_tag;
            mem_req.addr.fld.idx    = req_idx;
            mem_req.addr.fld.blkoff = blkoff;
            load                    = mem_load;
            if (!mem_wait)
            begin
               wr_c.en        = 1'b1;
               wr_c.wsel      = blkoff;
               wr_c.data      = cpu_req.wen ? cpu_req.store : mem_load;   // write miss merge
               wr_c.dirty_set = cpu_req.wen;
               hit            = 1'b1;
               lru_en         = 1'b1;
               lru_way        = vic_q;
               state_d        = idle;
            end
         end
         flush1:
         begin
            if (sline.valid && sline.dirty)
            begin
               mem_req.wen             = 1'b1;
               mem_req.addr.fld.tag    = sline.tag;
               mem_req.addr.fld.idx    = fset_q;
               mem_req.addr.fld.blkoff = 1'b0;
               mem_req.store           = sline.data[0];
               if (!mem_wait)
                  state_d = flush2;
            end
            else if (last_slot)
               state_d = cnt_wr;
            else
            begin
               fset_d = fset_nx;
               fway_d = fway_nx;
            end
         end
         flush2:
         begin
            mem_req.wen             = 1'b1;
            mem_req.addr.fld.tag    = sline.tag;
            mem_req.addr.fld.idx    = fset_q;
            mem_req.addr.fld.blkoff = 1'b1;
            mem_req.store           = sline.data[1];
            if (!mem_wait)
            begin
               wr_sel          = fway_q;
               wr_c.idx        = fset_q;
               wr_c.invalidate = 1'b1;
               if (last_slot)
                  state_d = cnt_wr;
               else
               begin
                  state_d = flush1;
                  fset_d  = fset_nx;
                  fway_d  = fway_nx;
               end
            end
         end
         cnt_wr:
         begin
            mem_req.wen      = 1'b1;
            mem_req.addr.raw = `DC_HITCNT_ADDR;
            mem_req.store    = count_q;
            if (!mem_wait)
               state_d = halted;
         end
         halted:
         begin
            hit     = 1'b1;
            flushed = 1'b1;
         end
         default:
            state_d = idle;
      endcase
   end

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         state_q <= idle;
         vic_q   <= 1'b0;
         fset_q  <= '0;
         fway_q  <= 1'b0;
         lru_q   <= '0;
         count_q <= '0;
      end
      else
      begin
         state_q <= state_d;
         vic_q   <= vic_d;
         fset_q  <= fset_d;
         fway_q  <= fway_d;
         if (lru_en)
            lru_q[req_idx] <= ~lru_way;   // other way becomes lru
         if (count_en)
            count_q <= count_q + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: rtl/dcache_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "dcache_config.svh"

module dcache_top
   import dcache_pkg::*;
(
   input  logic     CLK,
   input  logic     nRST,
   input  cpu_req_t cpu_req,
   input  logic     halt,
   output logic     hit,
   output word_t    load,
   output logic     flushed,
   output mem_req_t mem_req,
   input  logic     mem_wait,
   input  word_t    mem_load
);

   logic [`DC_IDX_W-1:0] rd_idx;
   logic [`DC_TAG_W-1:0] rd_tag;
   logic                 hit0;
   logic                 hit1;
   dc_line_t             line0;
   dc_line_t             line1;
   way_wr_t              wr0;
   way_wr_t              wr1;

   dcache_way u_way0 (
      .CLK    (CLK),
      .nRST   (nRST),
      .rd_idx (rd_idx),
      .rd_tag (rd_tag),
      .wr     (wr0),
      .hit    (hit0),
      .line   (line0)
   );

   dcache_way u_way1 (
      .CLK    (CLK),
      .nRST   (nRST),
      .rd_idx (rd_idx),
      .rd_tag (rd_tag),
      .wr     (wr1),
      .hit    (hit1),
      .line   (line1)
   );

   dcache_ctrl u_ctrl (
      .CLK      (CLK),
      .nRST     (nRST),
      .cpu_req  (cpu_req),
      .halt     (halt),
      .hit      (hit),
      .load     (load),
      .flushed  (flushed),
      .mem_req  (mem_req),
      .mem_wait (mem_wait),
      .mem_load (mem_load),
      .rd_idx   (rd_idx),
      .rd_tag   (rd_tag),
      .hit0     (hit0),
      .hit1     (hit1),
      .line0    (line0),
      .line1    (line1),
      .wr0      (wr0),
      .wr1      (wr1)
   );

endmodule

`default_nettype wire

// File: verification/dcache_clkgen.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_clkgen
(
   output logic CLK,
   output logic nRST
);

   initial
   begin
      CLK = 1'b0;
      forever
         #10 CLK = ~CLK;   // 20 ns period
   end

   initial
   begin
      nRST = 1'b0;
      repeat (2)
         @(posedge CLK);
      @(negedge CLK);
      nRST = 1'b1;   // released after two rising edges
   end

endmodule

`default_nettype wire

// File: verification/dcache_props.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_props
   import dcache_pkg::*;
(
   input logic     CLK,
   input logic     nRST,
   input mem_req_t mem_req,
   input logic     mem_wait,
   input logic     flushed
);

   int unsigned fail_count = 0;   // read by the testbench at the end

   // request frozen while memory stalls
   assert property (@(posedge CLK) disable iff (!nRST)
      ((mem_req.ren || mem_req.wen) && mem_wait) |=> $stable(mem_req))
   else
   begin
      fail_count++;
      $error("mem_req changed while mem_wait was high");
   end

   assert property (@(posedge CLK) disable iff (!nRST)
      !(mem_req.ren && mem_req.wen))
   else
   begin
      fail_count++;
      $error("mem_req has ren and wen set together");
   end

   // sticky until reset
   assert property (@(posedge CLK) disable iff (!nRST)
      flushed |=> flushed)
   else
   begin
      fail_count++;
      $error("flushed fell without a reset");
   end

endmodule

bind dcache_top dcache_props u_props (
   .CLK      (CLK),
   .nRST     (nRST),
   .mem_req  (mem_req),
   .mem_wait (mem_wait),
   .flushed  (flushed)
);

`default_nettype wire

// File: verification/dcache_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "dcache_config.svh"

module dcache_tb
   import dcache_pkg::*;
();

   localparam int    N_ACCESS    = 400;
   localparam int    CYCLE_LIMIT = N_ACCESS * 24 + 300;
   localparam word_t WIN_BASE    = 32'h0000_0400;   // 64 words, 4 tags per set
   localparam int    SAMPLE_DLY  = 5;

   typedef struct packed {
      logic  wen;
      word_t addr;
      word_t data;
   } xfer_t;

   logic     CLK;
   logic     nRST;
   cpu_req_t cpu_req;
   logic     halt;
   logic     hit;
   word_t    load;
   logic     flushed;
   mem_req_t mem_req;
   logic     mem_wait;
   word_t    mem_load;

   word_t                rng;
   word_t                backing [word_t];   // memory model contents
   word_t                golden [word_t];    // what the core should see
   word_t                touched [$];
   xfer_t                exp_q [$];
   logic                 m_valid [2][`DC_SETS];
   logic                 m_dirty [2][`DC_SETS];
   logic [`DC_TAG_W-1:0] m_tag [2][`DC_SETS];
   logic                 m_lru [`DC_SETS];
   word_t                hit_count;
   int                   ncycles;
   logic                 busy;
   logic [1:0]           wait_left;
   logic                 s_hit;
   logic                 s_flushed;
   word_t                s_load;
   mem_req_t             s_req;
   logic                 s_wait;
   word_t                last_wr_addr;
   word_t                last_wr_data;
   int                   last_wr_cycle;

   dcache_clkgen u_clkgen (
      .CLK  (CLK),
      .nRST (nRST)
   );

   dcache_top u_dut (
      .CLK      (CLK),
      .nRST     (nRST),
      .cpu_req  (cpu_req),
      .halt     (halt),
      .hit      (hit),
      .load     (load),
      .flushed  (flushed),
      .mem_req  (mem_req),
      .mem_wait (mem_wait),
      .mem_load (mem_load)
   );

   function automatic word_t xorshift(input word_t s);
      word_t x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic word_t next_rand();
      rng = xorshift(rng);
      return rng;
   endfunction

   function automatic word_t fill_word(input word_t a);
      return (a * 32'h9e37_79b1) ^ 32'h6c3a_91e5;
   endfunction

   function automatic word_t mem_read(input word_t a);
      return backing.exists(a) ? backing[a] : fill_word(a);
   endfunction

   function automatic word_t gold_read(input word_t a);
      return golden.exists(a) ? golden[a] : fill_word(a);
   endfunction

   function automatic word_t blk_addr(input logic [`DC_TAG_W-1:0] tag,
                                      input logic [`DC_IDX_W-1:0] idx,
                                      input logic                 b);
      return {tag, idx, b, 2'b00};
   endfunction

   task automatic abort_run(input string line);
      $display("%s", line);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic value_error(input string msg);
      abort_run($sformatf("FAIL at %0t: %s", $time, msg));
   endtask

   task automatic expect_xfer(input logic wen, input word_t addr, input word_t data);
      xfer_t x;
      x.wen  = wen;
      x.addr = addr;
      x.data = data;
      exp_q.push_back(x);
   endtask

   // one transfer done at this edge, compare in order
   task automatic finish_transfer();
      xfer_t x;
      assert (exp_q.size() != 0)
      else value_error($sformatf("unexpected memory transfer at %h", s_req.addr.raw));
      x = exp_q.pop_front();
      assert (s_req.wen == x.wen && s_req.addr.raw == x.addr)
      else value_error($sformatf("memory wen=%0b addr=%h, expected wen=%0b addr=%h",
                                 s_req.wen, s_req.addr.raw, x.wen, x.addr));
      if (x.wen)
      begin
         assert (s_req.store == x.data)
         else value_error($sformatf("memory write %h data %h, expected %h",
                                    x.addr, s_req.store, x.data));
      end
      if (s_req.wen)
      begin
         backing[s_req.addr.raw] = s_req.store;
         last_wr_addr            = s_req.addr.raw;
         last_wr_data            = s_req.store;
         last_wr_cycle           = ncycles;
      end
      busy = 1'b0;
   endtask

   task automatic drive_memory();
      word_t r;
      if (mem_req.ren || mem_req.wen)
      begin
         if (!busy)
         begin
            r         = next_rand();
            wait_left = r[1:0];   // 0 to 3 wait cycles
            busy      = 1'b1;
         end
         if (wait_left != 2'd0)
         begin
            mem_wait  = 1'b1;
            mem_load  = '0;
            wait_left = wait_left - 2'd1;
         end
         else
         begin
            mem_wait = 1'b0;
            mem_load = mem_req.ren ? mem_read(mem_req.addr.raw) : '0;
         end
      end
      else
      begin
         mem_wait = 1'b0;
         mem_load = '0;
      end
   endtask

   // called on a falling edge with inputs driven
   task automatic step_cycle();
      #(SAMPLE_DLY);
      s_hit     = hit;
      s_load    = load;
      s_flushed = flushed;
      s_req     = mem_req;
      s_wait    = mem_wait;
      if (!halt)
      begin
         assert (!s_flushed)
         else value_error("flushed high before halt");
      end
      @(posedge CLK);
      ncycles++;
      if (ncycles > CYCLE_LIMIT)
         abort_run($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
      if ((s_req.ren || s_req.wen) && !s_wait)
         finish_transfer();
      @(negedge CLK);
      drive_memory();
   endtask

   task automatic idle_cycle();
      cpu_req = '0;
      step_cycle();
      assert (s_hit)
      else value_error("hit low while idle with no request");
   endtask

   task automatic do_access(input logic wr, input word_t addr, input word_t data);
      logic [`DC_TAG_W-1:0] tag;
      logic [`DC_IDX_W-1:0] idx;
      logic                 b;
      logic                 h1;
      logic                 pred;
      logic                 way;
      logic                 first;
      logic                 done;
      word_t                va;
      tag  = addr[31:6];
      idx  = addr[5:3];
      b    = addr[2];
      h1   = m_valid[1][idx] && (m_tag[1][idx] == tag);
      pred = h1 || (m_valid[0][idx] && (m_tag[0][idx] == tag));
      if (pred)
         way = h1;
      else
      begin
         if (!m_valid[0][idx])
            way = 1'b0;
         else if (!m_valid[1][idx])
            way = 1'b1;
         else
            way = m_lru[idx];
         if (m_valid[way][idx] && m_dirty[way][idx])
         begin
            va = blk_addr(m_tag[way][idx], idx, 1'b0);
            expect_xfer(1'b1, va, gold_read(va));
            va = blk_addr(m_tag[way][idx], idx, 1'b1);
            expect_xfer(1'b1, va, gold_read(va));
         end
         expect_xfer(1'b0, blk_addr(tag, idx, ~b), '0);   // other word first
         expect_xfer(1'b0, blk_addr(tag, idx, b), '0);
      end

      cpu_req.ren      = ~wr;
      cpu_req.wen      = wr;
      cpu_req.addr.raw = addr;
      cpu_req.store    = data;
      first            = 1'b1;
      done             = 1'b0;
      while (!done)
      begin
         step_cycle();
         if (first)
         begin
            assert (s_hit == pred)
            else value_error($sformatf("%s %h hit=%0b in first cycle, expected %0b",
                                       wr ? "write" : "read", addr, s_hit, pred));
         end
         first = 1'b0;
         if (s_hit)
         begin
            done = 1'b1;
            if (!wr)
            begin
               assert (s_load == gold_read(addr))
               else value_error($sformatf("read %h returned %h, expected %h",
                                          addr, s_load, gold_read(addr)));
            end
         end
      end
      assert (exp_q.size() == 0)
      else value_error($sformatf("access to %h ended with %0d memory transfers missing",
                                 addr, exp_q.size()));

      if (pred)
         hit_count = hit_count + 32'd1;
      else
      begin
         m_valid[way][idx] = 1'b1;
         m_tag[way][idx]   = tag;
         m_dirty[way][idx] = 1'b0;
      end
      if (wr)
      begin
         m_dirty[way][idx] = 1'b1;
         if (!golden.exists(addr))
            touched.push_back(addr);
         golden[addr] = data;
      end
      m_lru[idx] = ~way;
      cpu_req    = '0;
   endtask

   initial
   begin
      int    s;
      int    w;
      int    n;
      word_t r;
      word_t a;
      word_t d;
      word_t va;
      cpu_req       = '0;
      halt          = 1'b0;
      mem_wait      = 1'b0;
      mem_load      = '0;
      rng           = 32'hd98f4ea5;
      hit_count     = '0;
      ncycles       = 0;
      busy          = 1'b0;
      wait_left     = '0;
      s_flushed     = 1'b0;
      last_wr_addr  = '0;
      last_wr_data  = '0;
      last_wr_cycle = 0;
      for (s = 0; s < `DC_SETS; s++)
      begin
         m_lru[s] = 1'b0;
         for (w = 0; w < 2; w++)
         begin
            m_valid[w][s] = 1'b0;
            m_dirty[w][s] = 1'b0;
            m_tag[w][s]   = '0;
         end
      end

      wait (nRST === 1'b1);
      @(negedge CLK);

      for (n = 0; n < N_ACCESS; n++)
      begin
         r = next_rand();
         a = WIN_BASE + {24'd0, r[5:0], 2'b00};
         if (r[9:8] == 2'd0)
            idle_cycle();
         d = next_rand();
         do_access(r[7], a, d);
      end

      // flush walk order is set by set, way 0 then way 1
      for (s = 0; s < `DC_SETS; s++)
      begin
         for (w = 0; w < 2; w++)
         begin
            if (m_valid[w][s] && m_dirty[w][s])
            begin
               va = blk_addr(m_tag[w][s], s[`DC_IDX_W-1:0], 1'b0);
               expect_xfer(1'b1, va, gold_read(va));
               va = blk_addr(m_tag[w][s], s[`DC_IDX_W-1:0], 1'b1);
               expect_xfer(1'b1, va, gold_read(va));
            end
         end
      end
      expect_xfer(1'b1, `DC_HITCNT_ADDR, hit_count);

      cpu_req = '0;
      halt    = 1'b1;
      while (!s_flushed)
         step_cycle();

      assert (exp_q.size() == 0)
      else value_error($sformatf("flushed rose with %0d flush writes missing", exp_q.size()));
      assert (last_wr_addr == `DC_HITCNT_ADDR && last_wr_data == hit_count)
      else value_error($sformatf("last write %h data %h, expected hit count %0d",
                                 last_wr_addr, last_wr_data, hit_count));
      assert (last_wr_cycle + 1 == ncycles)
      else value_error("flushed did not rise one cycle after the hit count write");
      foreach (touched[i])
      begin
         assert (mem_read(touched[i]) == gold_read(touched[i]))
         else value_error($sformatf("memory %h holds %h after flush, expected %h",
                                    touched[i], mem_read(touched[i]),
                                    gold_read(touched[i])));
      end

      repeat (2)
      begin
         step_cycle();
         assert (s_flushed && s_hit)
         else value_error("flushed or hit fell after the flush");
      end

      if (u_dut.u_props.fail_count == 0)
      begin
         $display("TEST PASSED");
         $finish;
      end
      else
         abort_run($sformatf("%0d bound assertion failures", u_dut.u_props.fail_count));
   end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+rtl
rtl/dcache_pkg.sv
rtl/dcache_way.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
verification/dcache_clkgen.sv
verification/dcache_props.sv
verification/dcache_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = dcache_tb
FLIST     = vlog.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir
